//--- files.f
+incdir+common
common/pipeTypesPkg.sv
common/exceptTypesPkg.sv
design/execUnit.sv
design/stageReg.sv
memStage/memAccess.sv
memStage/dataMem.sv
design/exceptCtrl.sv
design/backEndTop.sv
tests/backEndTb.sv

//--- run.sh
#!/bin/sh
# Build and run the back-end testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module backEndTb -o backEndSim &&
./obj_dir/backEndSim ||
exit 1

//--- tests/backEndTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module backEndTb;
    import pipeTypesPkg::*;
    import exceptTypesPkg::*;

    localparam int WaitLimit = 20;

    logic         clk;
    logic         reset;
    logic         flush;
    logic         issueValid;
    issueBundleT  issue;
    logic         retireValid;
    retireT       retire;
    logic         excValid;
    exceptReportT exc;
    logic [7:0]   excCount;

    logic [31:0]  lfsrState;
    logic [31:0]  pcNext;
    logic [31:0]  ramModel [`DMEM_WORDS];
    logic [7:0]   storedIdx [$];

    backEndTop dut_i (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issueValid  (issueValid),
        .issue       (issue),
        .retireValid (retireValid),
        .retire      (retire),
        .excValid    (excValid),
        .exc         (exc),
        .excCount    (excCount)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] newPc();
        logic [31:0] pc;
        pc = pcNext;
        pcNext = pcNext + 32'd4;
        return pc;
    endfunction

    function automatic issueBundleT makeInstr(input aluOpT op, input logic [31:0] a,
                                              input logic [31:0] b, input logic [15:0] imm,
                                              input logic useImm, input loadT ld,
                                              input storeT st, input logic [4:0] dst);
        issueBundleT t;
        t.valid     = 1'b1;
        t.pc        = newPc();
        t.opA       = a;
        t.opB       = b;
        t.imm       = imm;
        t.useImm    = useImm;
        t.aluOp     = op;
        t.loadType  = ld;
        t.storeType = st;
        t.dst       = dst;
        t.regWrite  = (st == stNone);
        return t;
    endfunction

    // Signed compare for slt and a 5-bit shift amount for sll
    function automatic logic [31:0] aluModel(input aluOpT op, input logic [31:0] a,
                                             input logic [31:0] b);
        case (op)
            aluAdd:  return a + b;
            aluSub:  return a - b;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluXor:  return a ^ b;
            aluSlt:  return {31'b0, $signed(a) < $signed(b)};
            aluSltu: return {31'b0, a < b};
            default: return a << b[4:0];
        endcase
    endfunction

    function automatic logic [31:0] loadModel(input loadT ld, input logic [31:0] word,
                                              input logic [1:0] off);
        logic [7:0]  b8;
        logic [15:0] h16;
        b8  = word[{off, 3'b000} +: 8];
        h16 = word[{off[1], 4'b0000} +: 16];
        case (ld)
            ldLb:    return {{24{b8[7]}}, b8};
            ldLbu:   return {24'b0, b8};
            ldLh:    return {{16{h16[15]}}, h16};
            ldLhu:   return {16'b0, h16};
            default: return word;
        endcase
    endfunction

    task automatic modelStore(input storeT st, input logic [31:0] addr, input logic [31:0] data);
        case (st)
            stSb: ramModel[addr[9:2]][{addr[1:0], 3'b000} +: 8] = data[7:0];
            stSh: ramModel[addr[9:2]][{addr[1], 4'b0000} +: 16] = data[15:0];
            stSw: ramModel[addr[9:2]] = data;
            default: ;
        endcase
    endtask

    task automatic failNow(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic checkEq(input string testName, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected)
        else failNow($sformatf("Error %s %s: expected %h, actual %h",
                               testName, what, expected, actual));
    endtask

    task automatic sendInstr(input issueBundleT b, input logic doFlush);
        @(posedge clk);
        issueValid <= 1'b1;
        issue      <= b;
        flush      <= doFlush;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        issueValid <= 1'b0;
        issue      <= '0;
        flush      <= 1'b0;
    endtask

    // Counts falling edges until the retire strobe shows up
    task automatic waitRetire(input string testName, output retireT r, output int cycles);
        cycles = 1;
        @(negedge clk);
        while (!retireValid) begin
            if (cycles >= WaitLimit) begin
                failNow($sformatf("Timeout in %s: no instruction retired", testName));
            end
            @(negedge clk);
            cycles++;
        end
        r = retire;
    endtask

    task automatic waitExc(input string testName, output exceptReportT e);
        int cycles;
        cycles = 1;
        @(negedge clk);
        while (!excValid) begin
            if (cycles >= WaitLimit) begin
                failNow($sformatf("Timeout in %s: no exception was reported", testName));
            end
            @(negedge clk);
            cycles++;
        end
        e = exc;
    endtask

    // Single instruction with a fixed latency of two cycles
    task automatic runOne(input string testName, input issueBundleT b, output retireT r);
        int cycles;
        sendInstr(b, 1'b0);
        idleCycle();
        waitRetire(testName, r, cycles);
        checkEq(testName, "latency", 32'd2, cycles);
        checkEq(testName, "pc", b.pc, r.pc);
        checkEq(testName, "dst", {27'b0, b.dst}, {27'b0, r.dst});
        checkEq(testName, "regWrite", {31'b0, b.regWrite}, {31'b0, r.regWrite});
    endtask

    task automatic doStore(input string testName, input storeT st, input logic [31:0] base,
                           input logic [15:0] imm, input logic [31:0] data);
        retireT r;
        runOne(testName, makeInstr(aluAdd, base, data, imm, 1'b0, ldNone, st, 5'd0), r);
        modelStore(st, base + {{16{imm[15]}}, imm}, data);
    endtask

    task automatic doLoad(input string testName, input loadT ld, input logic [31:0] base,
                          input logic [15:0] imm);
        retireT      r;
        logic [31:0] addr;
        addr = base + {{16{imm[15]}}, imm};
        runOne(testName, makeInstr(aluAdd, base, 32'd0, imm, 1'b0, ld, stNone, 5'd3), r);
        checkEq(testName, $sformatf("%s value", ld.name()),
                loadModel(ld, ramModel[addr[9:2]], addr[1:0]), r.value);
    endtask

    task automatic aluTest();
        retireT      r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] tmp;
        aluOpT       op;
        for (int k = 0; k < 8; k++) begin
            op  = aluOpT'(k[2:0]);
            a   = randBits(32);
            b   = randBits(32);
            tmp = randBits(5);
            runOne("aluTest", makeInstr(op, a, b, 16'h0, 1'b0, ldNone, stNone, tmp[4:0]), r);
            checkEq("aluTest", op.name(), aluModel(op, a, b), r.value);
        end
        // Negative immediate through the sign extension
        a   = randBits(32);
        tmp = randBits(16) | 32'h8000;
        runOne("aluTest", makeInstr(aluAdd, a, 32'd0, tmp[15:0], 1'b1, ldNone, stNone, 5'd9),
               r);
        checkEq("aluTest", "addi", a + {16'hffff, tmp[15:0]}, r.value);
    endtask

    task automatic wordTest();
        logic [31:0] tmp;
        logic [31:0] base;
        for (int k = 0; k < 4; k++) begin
            tmp  = randBits(8);
            base = {22'b0, tmp[7:0], 2'b00};
            storedIdx.push_back(tmp[7:0]);
            if (k % 2 == 0) begin
                doStore("wordTest", stSw, base, 16'h0, randBits(32));
                doLoad("wordTest", ldLw, base, 16'h0);
            end else begin
                doStore("wordTest", stSw, base + 32'd4, 16'hfffc, randBits(32));
                doLoad("wordTest", ldLw, base + 32'd4, 16'hfffc);
            end
        end
    endtask

    task automatic byteHalfTest();
        logic [31:0] tmp;
        logic [31:0] base;
        tmp  = randBits(8);
        base = {22'b0, tmp[7:0], 2'b00};
        doStore("byteHalfTest", stSw, base, 16'h0, randBits(32));
        // Sign bits set so lb and lh must extend with ones
        doStore("byteHalfTest", stSb, base, 16'd1, randBits(8) | 32'h80);
        doStore("byteHalfTest", stSh, base, 16'd2, randBits(16) | 32'h8000);
        for (int off = 0; off < 4; off++) begin
            doLoad("byteHalfTest", ldLb, base, off[15:0]);
            doLoad("byteHalfTest", ldLbu, base, off[15:0]);
            if (off % 2 == 0) begin
                doLoad("byteHalfTest", ldLh, base, off[15:0]);
                doLoad("byteHalfTest", ldLhu, base, off[15:0]);
            end
        end
    endtask

    task automatic streamTest();
        issueBundleT stream [8];
        logic [31:0] expVal [8];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] tmp;
        logic [7:0]  idx;
        aluOpT       op;
        retireT      r;
        int          cycles;
        for (int i = 0; i < 8; i++) begin
            if (i % 2 == 0) begin
                tmp = randBits(3);
                op  = aluOpT'(tmp[2:0]);
                a   = randBits(32);
                b   = randBits(32);
                stream[i] = makeInstr(op, a, b, 16'h0, 1'b0, ldNone, stNone, 5'd7);
                expVal[i] = aluModel(op, a, b);
            end else begin
                idx = storedIdx[i % storedIdx.size()];
                stream[i] = makeInstr(aluAdd, {22'b0, idx, 2'b00}, 32'd0, 16'h0, 1'b0,
                                      ldLw, stNone, 5'd8);
                expVal[i] = ramModel[idx];
            end
        end
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    sendInstr(stream[i], 1'b0);
                end
                idleCycle();
            end
            begin
                waitRetire("streamTest", r, cycles);
                for (int i = 0; i < 8; i++) begin
                    if (i > 0) begin
                        @(negedge clk);
                        assert (retireValid)
                        else failNow("streamTest: gap in the retire stream");
                        r = retire;
                    end
                    checkEq("streamTest", "pc", stream[i].pc, r.pc);
                    checkEq("streamTest", "value", expVal[i], r.value);
                end
            end
        join
    endtask

    // Faulting access, then a victim that is flushed, then one that survives
    task automatic misalignCase(input string testName, input issueBundleT bad,
                                input exceptCauseT cause, input logic [7:0] idx);
        issueBundleT  victim;
        issueBundleT  survivor;
        exceptReportT e;
        retireT       r;
        int           cycles;
        logic [7:0]   countBefore;
        countBefore = excCount;
        victim   = makeInstr(aluOr, randBits(32), randBits(32), 16'h0, 1'b0, ldNone, stNone,
                             5'd4);
        survivor = makeInstr(aluXor, randBits(32), randBits(32), 16'h0, 1'b0, ldNone, stNone,
                             5'd5);
        fork
            begin
                sendInstr(bad, 1'b0);
                sendInstr(victim, 1'b0);
                sendInstr(survivor, 1'b0);
                idleCycle();
            end
            begin
                waitExc(testName, e);
                assert (e.cause == cause)
                else failNow($sformatf("Error %s cause: expected %s, actual %s",
                                       testName, cause.name(), e.cause.name()));
                checkEq(testName, "epc", bad.pc, e.pc);
                waitRetire(testName, r, cycles);
                checkEq(testName, "first retired pc", survivor.pc, r.pc);
                checkEq(testName, "value", aluModel(aluXor, survivor.opA, survivor.opB),
                        r.value);
            end
        join
        checkEq(testName, "excCount", {24'b0, countBefore + 8'd1}, {24'b0, excCount});
        // Recorded cause and EPC stay visible once the strobe is gone
        assert (exc.cause == cause)
        else failNow($sformatf("Error %s recorded cause: expected %s, actual %s",
                               testName, cause.name(), exc.cause.name()));
        checkEq(testName, "recorded epc", bad.pc, exc.pc);
        doLoad(testName, ldLw, {22'b0, idx, 2'b00}, 16'h0);
    endtask

    task automatic misalignTest();
        logic [7:0]  idx;
        logic [31:0] base;
        idx  = storedIdx[0];
        base = {22'b0, idx, 2'b00};
        misalignCase("misalignLw",
                     makeInstr(aluAdd, base, 32'd0, 16'd1, 1'b0, ldLw, stNone, 5'd6),
                     excAdel, idx);
        misalignCase("misalignSh",
                     makeInstr(aluAdd, base, randBits(32), 16'd3, 1'b0, ldNone, stSh, 5'd0),
                     excAdes, idx);
    endtask

    task automatic flushTest();
        issueBundleT squashed;
        issueBundleT kept;
        retireT      r;
        int          cycles;
        logic [7:0]  countBefore;
        countBefore = excCount;
        squashed = makeInstr(aluAdd, randBits(32), randBits(32), 16'h0, 1'b0, ldNone, stNone,
                             5'd10);
        kept     = makeInstr(aluSub, randBits(32), randBits(32), 16'h0, 1'b0, ldNone, stNone,
                             5'd11);
        fork
            begin
                sendInstr(squashed, 1'b1);
                sendInstr(kept, 1'b0);
                idleCycle();
            end
            begin
                waitRetire("flushTest", r, cycles);
                checkEq("flushTest", "first retired pc", kept.pc, r.pc);
                checkEq("flushTest", "value", aluModel(aluSub, kept.opA, kept.opB), r.value);
            end
        join
        checkEq("flushTest", "excCount", {24'b0, countBefore}, {24'b0, excCount});
    endtask

    initial begin
        reset      = 1'b1;
        flush      = 1'b0;
        issueValid = 1'b0;
        issue      = '0;
        lfsrState  = 32'hfeb18c93;
        pcNext     = 32'h0000_0400;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!retireValid && !excValid)
        else failNow("Retire or exception strobe active right after reset");
        checkEq("resetState", "excCount", 32'd0, {24'b0, excCount});

        aluTest();
        wordTest();
        byteHalfTest();
        streamTest();
        misalignTest();
        flushTest();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/backEndTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module backEndTop (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            flush,
    input  logic                            issueValid,
    input  pipeTypesPkg::issueBundleT       issue,
    output logic                            retireValid,
    output pipeTypesPkg::retireT            retire,
    output logic                            excValid,
    output exceptTypesPkg::exceptReportT    exc,
    output logic [7:0]                      excCount
);
    import pipeTypesPkg::*;
    import exceptTypesPkg::*;

    issueBundleT                        issueQual;
    exeMemBundleT                       exeMemD;
    exeMemBundleT                       exeMemQ;
    memWbBundleT                        memWbD;
    memWbBundleT                        memWbQ;
    logic [$clog2(`DMEM_WORDS)-1:0]     ramAddr;
    logic                               ramWe;
    logic [3:0]                         ramByteEn;
    logic [`DATA_W-1:0]                 ramWdata;
    logic [`DATA_W-1:0]                 ramRdata;
    logic                               misalign;
    exceptCauseT                        misalignCause;
    logic                               stageFlush;

    // Valid is the top bit of the issue bundle
    assign issueQual = {issue.valid && issueValid, issue[$bits(issueBundleT)-2:0]};

    execUnit exec (
        .issue  (issueQual),
        .exeMem (exeMemD)
    );

    stageReg #(.payloadT(exeMemBundleT)) exeMemReg (
        .clk   (clk),
        .reset (reset),
        .flush (stageFlush),
        .d     (exeMemD),
        .q     (exeMemQ)
    );

    memAccess memAcc (
        .clk           (clk),
        .reset         (reset),
        .exeMem        (exeMemQ),
        .memWb         (memWbD),
        .memWbQ        (memWbQ),
        .ramAddr       (ramAddr),
        .ramWe         (ramWe),
        .ramByteEn     (ramByteEn),
        .ramWdata      (ramWdata),
        .ramRdata      (ramRdata),
        .misalign      (misalign),
        .misalignCause (misalignCause),
        .retireValid   (retireValid),
        .retire        (retire)
    );

    stageReg #(.payloadT(memWbBundleT)) memWbReg (
        .clk   (clk),
        .reset (reset),
        .flush (1'b0),
        .d     (memWbD),
        .q     (memWbQ)
    );

    dataMem dmem (
        .clk    (clk),
        .addr   (ramAddr),
        .we     (ramWe),
        .byteEn (ramByteEn),
        .wdata  (ramWdata),
        .rdata  (ramRdata)
    );

    exceptCtrl excCtrl (
        .clk           (clk),
        .reset         (reset),
        .misalign      (misalign),
        .misalignCause (misalignCause),
        .misalignPc    (exeMemQ.pc),
        .extFlush      (flush),
        .stageFlush    (stageFlush),
        .excValid      (excValid),
        .exc           (exc),
        .excCount      (excCount)
    );

endmodule

`default_nettype wire

//--- design/exceptCtrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module exceptCtrl (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            misalign,
    input  exceptTypesPkg::exceptCauseT     misalignCause,
    input  logic [`DATA_W-1:0]              misalignPc,
    input  logic                            extFlush,
    output logic                            stageFlush,
    output logic                            excValid,
    output exceptTypesPkg::exceptReportT    exc,
    output logic [7:0]                      excCount
);
    import exceptTypesPkg::*;

    exceptCauseT        causeQ;
    logic [`DATA_W-1:0] epcQ;

    always_ff @(posedge clk) begin
        if (reset) begin
            causeQ   <= excNone;
            epcQ     <= '0;
            excCount <= 8'd0;
        end else if (misalign) begin
            causeQ <= misalignCause;
            epcQ   <= misalignPc;
            // Count sticks at its maximum
            if (excCount != 8'hff) begin
                excCount <= excCount + 8'd1;
            end
        end
    end

    // Live fault while it is in the memory stage or else the last recorded one
    assign excValid = misalign;
    assign exc = misalign ? exceptReportT'{cause: misalignCause, pc: misalignPc}
                          : exceptReportT'{cause: causeQ, pc: epcQ};

    // Kill the younger instruction entering EXE/MEM
    assign stageFlush = extFlush || misalign;

endmodule

`default_nettype wire

//--- memStage/dataMem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module dataMem (
    input  logic                            clk,
    input  logic [$clog2(`DMEM_WORDS)-1:0]  addr,
    input  logic                            we,
    input  logic [3:0]                      byteEn,
    input  logic [`DATA_W-1:0]              wdata,
    output logic [`DATA_W-1:0]              rdata
);

    logic [`DATA_W-1:0] mem [`DMEM_WORDS];

    // Byte lanes written independently
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEn[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Registered read with one cycle of latency
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

//--- memStage/memAccess.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module memAccess (
    input  logic                                clk,
    input  logic                                reset,
    input  pipeTypesPkg::exeMemBundleT          exeMem,
    output pipeTypesPkg::memWbBundleT           memWb,
    input  pipeTypesPkg::memWbBundleT           memWbQ,
    output logic [$clog2(`DMEM_WORDS)-1:0]      ramAddr,
    output logic                                ramWe,
    output logic [3:0]                          ramByteEn,
    output logic [`DATA_W-1:0]                  ramWdata,
    input  logic [`DATA_W-1:0]                  ramRdata,
    output logic                                misalign,
    output exceptTypesPkg::exceptCauseT         misalignCause,
    output logic                                retireValid,
    output pipeTypesPkg::retireT                retire
);
    import pipeTypesPkg::*;
    import exceptTypesPkg::*;

    logic               loadMis;
    logic               storeMis;
    logic [`DATA_W-1:0] shifted;
    logic [`DATA_W-1:0] wbValue;

    // Halfwords need bit 0 clear, words need both low bits clear
    always_comb begin
        case (exeMem.loadType)
            ldLh, ldLhu: loadMis = exeMem.aluOut[0];
            ldLw:        loadMis = |exeMem.aluOut[1:0];
            default:     loadMis = 1'b0;
        endcase
        case (exeMem.storeType)
            stSh:    storeMis = exeMem.aluOut[0];
            stSw:    storeMis = |exeMem.aluOut[1:0];
            default: storeMis = 1'b0;
        endcase
    end

    assign misalign      = exeMem.valid && (loadMis || storeMis);
    assign misalignCause = !misalign ? excNone : (storeMis ? excAdes : excAdel);

    assign ramAddr   = exeMem.aluOut[$clog2(`DMEM_WORDS)+1:2];
    assign ramWe     = exeMem.valid && (exeMem.storeType != stNone) && !misalign;
    assign ramByteEn = exeMem.byteEn;
    assign ramWdata  = exeMem.storeData;

    // A faulting access is dropped here and never reaches writeback
    assign memWb = '{
        valid:    exeMem.valid && !misalign,
        pc:       exeMem.pc,
        aluOut:   exeMem.aluOut,
        loadType: exeMem.loadType,
        addrLow:  exeMem.aluOut[1:0],
        dst:      exeMem.dst,
        regWrite: exeMem.regWrite
    };

    // Bring the addressed byte or halfword down to bit 0
    assign shifted = ramRdata >> {memWbQ.addrLow, 3'b000};

    always_comb begin
        case (memWbQ.loadType)
            ldLb:    wbValue = {{(`DATA_W - 8){shifted[7]}}, shifted[7:0]};
            ldLbu:   wbValue = {{(`DATA_W - 8){1'b0}}, shifted[7:0]};
            ldLh:    wbValue = {{(`DATA_W - 16){shifted[15]}}, shifted[15:0]};
            ldLhu:   wbValue = {{(`DATA_W - 16){1'b0}}, shifted[15:0]};
            ldLw:    wbValue = ramRdata;
            default: wbValue = memWbQ.aluOut;
        endcase
    end

    assign retireValid = memWbQ.valid;
    assign retire = '{
        pc:       memWbQ.pc,
        dst:      memWbQ.dst,
        regWrite: memWbQ.regWrite,
        value:    wbValue
    };

    noWriteOnFault: assert property (
        @(posedge clk) disable iff (reset) !(ramWe && misalign)
    ) else $error("RAM write issued for a misaligned access");

endmodule

`default_nettype wire

//--- design/stageReg.sv
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // No stall path, so the register loads on every edge
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

    // A cleared bundle is an invalid bundle
    clearedAfterFlush: assert property (
        @(posedge clk) (reset || flush) |=> (q == '0)
    ) else $error("stageReg not cleared after reset or flush");

endmodule

`default_nettype wire

//--- design/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module execUnit (
    input  pipeTypesPkg::issueBundleT  issue,
    output pipeTypesPkg::exeMemBundleT exeMem
);
    import pipeTypesPkg::*;

    logic [`DATA_W-1:0] immExt;
    logic [`DATA_W-1:0] srcB;
    logic [`DATA_W-1:0] aluRes;
    logic [`DATA_W-1:0] effAddr;
    logic [`DATA_W-1:0] laneData;
    logic [3:0]         byteEn;
    logic               isMem;

    assign immExt = {{(`DATA_W - 16){issue.imm[15]}}, issue.imm};
    assign srcB   = issue.useImm ? immExt : issue.opB;

    always_comb begin
        case (issue.aluOp)
            aluAdd:  aluRes = issue.opA + srcB;
            aluSub:  aluRes = issue.opA - srcB;
            aluAnd:  aluRes = issue.opA & srcB;
            aluOr:   aluRes = issue.opA | srcB;
            aluXor:  aluRes = issue.opA ^ srcB;
            aluSlt:  aluRes = {{(`DATA_W - 1){1'b0}}, $signed(issue.opA) < $signed(srcB)};
            aluSltu: aluRes = {{(`DATA_W - 1){1'b0}}, issue.opA < srcB};
            default: aluRes = issue.opA << srcB[4:0];
        endcase
    end

    // Base register plus offset for loads and stores
    assign effAddr = issue.opA + immExt;
    assign isMem   = (issue.loadType != ldNone) || (issue.storeType != stNone);

    // Store data is replicated across lanes and the byte enables pick the lane
    always_comb begin
        case (issue.storeType)
            stSb: begin
                laneData = {4{issue.opB[7:0]}};
                byteEn   = 4'b0001 << effAddr[1:0];
            end
            stSh: begin
                laneData = {2{issue.opB[15:0]}};
                byteEn   = effAddr[1] ? 4'b1100 : 4'b0011;
            end
            stSw: begin
                laneData = issue.opB;
                byteEn   = 4'b1111;
            end
            default: begin
                laneData = issue.opB;
                byteEn   = 4'b0000;
            end
        endcase
    end

    assign exeMem = '{
        valid:     issue.valid,
        pc:        issue.pc,
        aluOut:    isMem ? effAddr : aluRes,
        storeData: laneData,
        byteEn:    byteEn,
        loadType:  issue.loadType,
        storeType: issue.storeType,
        dst:       issue.dst,
        regWrite:  issue.regWrite
    };

endmodule

`default_nettype wire

//--- common/exceptTypesPkg.sv
`default_nettype none

`include "cpu_consts.svh"

package exceptTypesPkg;

    // Address error on load (adel) or on store (ades)
    typedef enum logic [1:0] {
        excNone,
        excAdel,
        excAdes
    } exceptCauseT;

    typedef struct packed {
        exceptCauseT         cause;
        logic [`DATA_W-1:0]  pc;
    } exceptReportT;

endpackage

`default_nettype wire

//--- common/pipeTypesPkg.sv
`default_nettype none

`include "cpu_consts.svh"

package pipeTypesPkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll
    } aluOpT;

    typedef enum logic [2:0] {
        ldNone,
        ldLb,
        ldLbu,
        ldLh,
        ldLhu,
        ldLw
    } loadT;

    typedef enum logic [1:0] {
        stNone,
        stSb,
        stSh,
        stSw
    } storeT;

    // Valid stays the first field because the top level qualifies it by position
    typedef struct packed {
        logic                valid;
        logic [`DATA_W-1:0]  pc;
        logic [`DATA_W-1:0]  opA;
        logic [`DATA_W-1:0]  opB;
        logic [15:0]         imm;
        logic                useImm;
        aluOpT               aluOp;
        loadT                loadType;
        storeT               storeType;
        logic [`REG_AW-1:0]  dst;
        logic                regWrite;
    } issueBundleT;

    typedef struct packed {
        logic                valid;
        logic [`DATA_W-1:0]  pc;
        logic [`DATA_W-1:0]  aluOut;
        logic [`DATA_W-1:0]  storeData;
        logic [3:0]          byteEn;
        loadT                loadType;
        storeT               storeType;
        logic [`REG_AW-1:0]  dst;
        logic                regWrite;
    } exeMemBundleT;

    typedef struct packed {
        logic                valid;
        logic [`DATA_W-1:0]  pc;
        logic [`DATA_W-1:0]  aluOut;
        loadT                loadType;
        logic [1:0]          addrLow;
        logic [`REG_AW-1:0]  dst;
        logic                regWrite;
    } memWbBundleT;

    typedef struct packed {
        logic [`DATA_W-1:0]  pc;
        logic [`REG_AW-1:0]  dst;
        logic                regWrite;
        logic [`DATA_W-1:0]  value;
    } retireT;

endpackage

`default_nettype wire

//--- common/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath and address width
`define DATA_W 32

// Destination register number width
`define REG_AW 5

// Data RAM size in 32-bit words
`define DMEM_WORDS 256

`endif
